//--- sim.f
+incdir+common
common/icache_pkg.sv
icache/icache_ctrl.sv
icache/icache_req_buf.sv
icache/icache_ways.sv
icache/icache_rdata_sel.sv
rtl/icache_top.sv
verif/icache_mem_model.sv
verif/tb_icache.sv

//--- verif/icache_testdata.txt
// columns: test id, op (0 fetch, 1 mem write, f end), address, uncached,
// expected pair or write data in the low word, expected excp, memory request expected
1_0_00000040_0_a5a50011a5a50010_0_1
1_0_00000040_0_a5a50011a5a50010_0_0
2_0_00000048_0_a5a50013a5a50012_0_0
2_0_00000058_0_a5a50017a5a50016_0_0
2_0_00000078_0_a5a5001fa5a5001e_0_0
2_0_00000044_0_a5a50011a5a50010_0_0
3_0_00000100_0_a5a50041a5a50040_0_1
3_0_00001100_0_a5a50441a5a50440_0_1
3_0_00000100_0_a5a50041a5a50040_0_0
3_0_00002100_0_a5a50841a5a50840_0_1
3_0_00000100_0_a5a50041a5a50040_0_0
3_0_00001100_0_a5a50441a5a50440_0_1
4_1_00000100_0_00000000deadbeef_0_0
4_0_00000100_0_a5a50041a5a50040_0_0
4_0_00000100_1_a5a50041deadbeef_0_1
4_0_00000104_1_a5a50041deadbeef_0_1
5_0_00000102_0_0340000003400000_1_0
5_0_00000041_1_0340000003400000_1_0
0_f_00000000_0_0000000000000000_0_0

//--- verif/tb_icache.sv
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam time PERIOD    = 100ns;
    localparam int  MAX_OPS   = 64;
    localparam int  RESP_WAIT = 12;

    logic       clk;
    logic       rstn;
    logic       fetch_valid;
    addr_t      fetch_addr;
    logic       fetch_uncached;
    logic       fetch_ready;
    logic       resp_valid;
    fetch_t     resp_data;
    addr_t      resp_addr;
    logic       resp_excp;
    logic       mem_req;
    addr_t      mem_addr;
    logic [7:0] mem_len;
    logic       mem_ready;
    line_t      mem_data;
    logic       wr_en;
    addr_t      wr_addr;
    logic [31:0] wr_data;

    // id, op, addr, uncached, pair, excp, request flag
    logic [115:0] vectors [MAX_OPS];
    int   num_ops;
    logic loaded;
    int   req_count;
    logic mem_req_q;
    int   mismatches;
    int   failures;

    // address and length seen when the request rose
    addr_t      seen_mem_addr;
    logic [7:0] seen_mem_len;

    icache_top dut0 (
        .clk              (clk),
        .rstn             (rstn),
        .i_fetch_valid    (fetch_valid),
        .i_fetch_addr     (fetch_addr),
        .i_fetch_uncached (fetch_uncached),
        .o_fetch_ready    (fetch_ready),
        .o_resp_valid     (resp_valid),
        .o_resp_data      (resp_data),
        .o_resp_addr      (resp_addr),
        .o_resp_excp      (resp_excp),
        .o_mem_req        (mem_req),
        .o_mem_addr       (mem_addr),
        .o_mem_len        (mem_len),
        .i_mem_ready      (mem_ready),
        .i_mem_data       (mem_data)
    );

    icache_mem_model #(.WORDS(4096)) u_mem (
        .clk       (clk),
        .rstn      (rstn),
        .i_req     (mem_req),
        .i_addr    (mem_addr),
        .i_len     (mem_len),
        .o_ready   (mem_ready),
        .o_data    (mem_data),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

    // rising edges of the memory request
    always @(posedge clk) begin
        if (!rstn) begin
            mem_req_q <= 1'b0;
        end else begin
            mem_req_q <= mem_req;
            if (mem_req && !mem_req_q) begin
                req_count++;
                seen_mem_addr = mem_addr;
                seen_mem_len  = mem_len;
            end
        end
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'h1: return "cold_miss";
            4'h2: return "line_offsets";
            4'h3: return "lru_replace";
            4'h4: return "uncached_bypass";
            4'h5: return "misaligned";
            default: return "unnamed";
        endcase
    endfunction

    task automatic write_word(input addr_t addr, input logic [31:0] data);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic run_fetch(input string name, input addr_t addr, input logic unc,
                             input fetch_t exp_data, input logic exp_excp, input logic exp_req);
        int         waited;
        addr_t      exp_mem_addr;
        logic [7:0] exp_mem_len;
        @(negedge clk);
        req_count      = 0;
        fetch_valid    = 1'b1;
        fetch_addr     = addr;
        fetch_uncached = unc;
        waited         = 0;
        while (!fetch_ready && waited < RESP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (fetch_ready) else begin
            $display("%s: fetch of %h was never accepted", name, addr);
            failures++;
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        waited      = 0;
        while (!resp_valid && waited < RESP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (resp_valid) else begin
            $display("%s: no response for fetch of %h", name, addr);
            failures++;
        end
        if (!resp_valid) begin
            return;
        end
        // hits and misaligned fetches answer in the cycle after acceptance
        if (!exp_req) begin
            assert (waited == 0) else begin
                $display("MISMATCH %s: latency expected 1 actual %0d", name, waited + 1);
                mismatches++;
            end
        end
        assert (resp_data == exp_data) else begin
            $display("MISMATCH %s: data expected %h actual %h", name, exp_data, resp_data);
            mismatches++;
        end
        assert (resp_excp == exp_excp) else begin
            $display("MISMATCH %s: excp expected %0b actual %0b", name, exp_excp, resp_excp);
            mismatches++;
        end
        assert (resp_addr == addr) else begin
            $display("MISMATCH %s: addr expected %h actual %h", name, addr, resp_addr);
            mismatches++;
        end
        assert (req_count == int'(exp_req)) else begin
            $display("MISMATCH %s: mem requests expected %0d actual %0d",
                     name, exp_req, req_count);
            mismatches++;
        end
        // 64-byte line read of 16 beats, or one doubleword of 2 beats
        if (exp_req && req_count > 0) begin
            if (unc) begin
                exp_mem_addr = addr & ~32'h0000_0007;
                exp_mem_len  = 8'd1;
            end else begin
                exp_mem_addr = addr & ~32'h0000_003f;
                exp_mem_len  = 8'd15;
            end
            assert (seen_mem_addr == exp_mem_addr) else begin
                $display("MISMATCH %s: mem addr expected %h actual %h",
                         name, exp_mem_addr, seen_mem_addr);
                mismatches++;
            end
            assert (seen_mem_len == exp_mem_len) else begin
                $display("MISMATCH %s: mem len expected %0d actual %0d",
                         name, exp_mem_len, seen_mem_len);
                mismatches++;
            end
        end
    endtask

    initial begin
        logic [115:0] vec;
        void'($urandom(32'h5151));
        rstn           = 1'b0;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        fetch_uncached = 1'b0;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        mismatches     = 0;
        failures       = 0;
        req_count      = 0;
        seen_mem_addr  = '0;
        seen_mem_len   = '0;
        num_ops        = 0;
        loaded         = 1'b0;
        $readmemh("verif/icache_testdata.txt", vectors);
        while (num_ops < MAX_OPS && vectors[num_ops][111:108] != 4'hf) begin
            num_ops++;
        end
        loaded = 1'b1;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < num_ops; i++) begin
            vec = vectors[i];
            if (vec[111:108] == 4'h1) begin
                write_word(vec[107:76], vec[39:8]);
            end else begin
                run_fetch(test_name(vec[115:112]), vec[107:76], vec[72], vec[71:8],
                          vec[4], vec[0]);
            end
        end
        repeat (2) @(negedge clk);
        assert (!mem_req) else begin
            $display("memory request raised after the last fetch");
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // 20 cycles per line plus one spare line for reset
    initial begin
        wait (loaded === 1'b1);
        #((num_ops + 1) * 20 * PERIOD);
        $display("watchdog expired before the test list finished");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verif/icache_mem_model.sv
module icache_mem_model #(
    parameter int WORDS = 4096
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_req,
    input  icache_pkg::addr_t  i_addr,
    input  logic [7:0]         i_len,
    output logic               o_ready,
    output icache_pkg::line_t  o_data,
    input  logic               i_wr_en,
    input  icache_pkg::addr_t  i_wr_addr,
    input  logic [31:0]        i_wr_data
);
    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic        busy;
    int unsigned wait_cnt;

    // every word carries its own word address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = i ^ 32'hA5A5_0000;
        end
    end

    // len+1 beats of 32 bits from the given address, rest zero
    function automatic line_t read_burst(input addr_t addr, input logic [7:0] len);
        line_t data;
        int    base;
        data = '0;
        base = int'(addr[AW+1:2]);
        for (int j = 0; j < 16; j++) begin
            if (j <= int'(len)) begin
                data[32*j +: 32] = mem[(base + j) % WORDS];
            end
        end
        return data;
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            o_ready  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else begin
            o_ready <= 1'b0;
            if (i_wr_en) begin
                mem[i_wr_addr[AW+1:2]] <= i_wr_data;
            end
            // ready follows 1 to 4 cycles after the request is first seen
            if (i_req && !o_ready) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= $urandom_range(3, 0);
                end else if (wait_cnt == 0) begin
                    busy    <= 1'b0;
                    o_ready <= 1'b1;
                    o_data  <= read_burst(i_addr, i_len);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

//--- rtl/icache_top.sv
module icache_top (
    input  logic                 clk,
    input  logic                 rstn,

    // fetch request
    input  logic                 i_fetch_valid,
    input  icache_pkg::addr_t    i_fetch_addr,
    input  logic                 i_fetch_uncached,
    output logic                 o_fetch_ready,

    // response strobe
    output logic                 o_resp_valid,
    output icache_pkg::fetch_t   o_resp_data,
    output icache_pkg::addr_t    o_resp_addr,
    output logic                 o_resp_excp,

    // memory read
    output logic                 o_mem_req,
    output icache_pkg::addr_t    o_mem_addr,
    output logic [7:0]           o_mem_len,
    input  logic                 i_mem_ready,
    input  icache_pkg::line_t    i_mem_data
);
    import icache_pkg::*;

    // controller strobes
    logic   accept;
    logic   line_we;
    logic   lru_touch;
    logic   from_mem;

    // request state
    logic   misaligned;
    logic   uncached;
    addr_t  req_addr;
    line_t  ret_line;

    // lookup result
    logic   hit;
    line_t  hit_line;

    assign o_resp_addr = req_addr;
    assign o_resp_excp = misaligned;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_fetch_valid (i_fetch_valid),
        .i_hit         (hit),
        .i_misaligned  (misaligned),
        .i_uncached    (uncached),
        .i_mem_ready   (i_mem_ready),
        .o_fetch_ready (o_fetch_ready),
        .o_accept      (accept),
        .o_line_we     (line_we),
        .o_lru_touch   (lru_touch),
        .o_from_mem    (from_mem),
        .o_mem_req     (o_mem_req),
        .o_resp_valid  (o_resp_valid)
    );

    icache_req_buf u_req_buf (
        .clk              (clk),
        .rstn             (rstn),
        .i_accept         (accept),
        .i_fetch_addr     (i_fetch_addr),
        .i_fetch_uncached (i_fetch_uncached),
        .i_mem_ready      (i_mem_ready),
        .i_mem_data       (i_mem_data),
        .o_req_addr       (req_addr),
        .o_uncached       (uncached),
        .o_misaligned     (misaligned),
        .o_mem_addr       (o_mem_addr),
        .o_mem_len        (o_mem_len),
        .o_ret_line       (ret_line)
    );

    // hit way only steers the line select and lru inside the ways block
    icache_ways u_ways (
        .clk          (clk),
        .rstn         (rstn),
        .i_accept     (accept),
        .i_fetch_addr (i_fetch_addr),
        .i_req_addr   (req_addr),
        .i_line_we    (line_we),
        .i_lru_touch  (lru_touch),
        .i_ret_line   (ret_line),
        .o_hit        (hit),
        .o_hit_way    (),
        .o_hit_line   (hit_line)
    );

    icache_rdata_sel u_rdata_sel (
        .i_from_mem   (from_mem),
        .i_hit_line   (hit_line),
        .i_ret_line   (ret_line),
        .i_req_addr   (req_addr),
        .i_uncached   (uncached),
        .i_misaligned (misaligned),
        .o_resp_data  (o_resp_data)
    );

endmodule

//--- icache/icache_rdata_sel.sv
`include "icache_macros.svh"

module icache_rdata_sel (
    input  logic               i_from_mem,
    input  icache_pkg::line_t  i_hit_line,
    input  icache_pkg::line_t  i_ret_line,
    input  icache_pkg::addr_t  i_req_addr,
    input  logic               i_uncached,
    input  logic               i_misaligned,
    output icache_pkg::fetch_t o_resp_data
);
    import icache_pkg::*;

    line_t  src_line;
    fetch_t line_pair;
    fetch_t data_pair;

    // array line on a hit, returned line on a refill
    assign src_line = i_from_mem ? i_ret_line : i_hit_line;

    // doubleword slot within the line
    assign line_pair = src_line[{i_req_addr[5:3], 6'b000000} +: `ICACHE_FETCH_W];

    // uncached reads come back in the low doubleword
    assign data_pair = i_uncached ? i_ret_line[`ICACHE_FETCH_W-1:0] : line_pair;

    always_comb begin
        if (i_misaligned) begin
            o_resp_data = {`ICACHE_INST_NOP, `ICACHE_INST_NOP};
        end else begin
            o_resp_data = data_pair;
        end
    end

endmodule

//--- icache/icache_ways.sv
`include "icache_macros.svh"

module icache_ways (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_accept,
    input  icache_pkg::addr_t  i_fetch_addr,
    input  icache_pkg::addr_t  i_req_addr,
    input  logic               i_line_we,
    input  logic               i_lru_touch,
    input  icache_pkg::line_t  i_ret_line,
    output logic               o_hit,
    output icache_pkg::way_t   o_hit_way,
    output icache_pkg::line_t  o_hit_line
);
    import icache_pkg::*;

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    // read side uses the incoming fetch, write side the held request
    index_t rd_index;
    index_t wr_index;
    tag_t   req_tag;

    // arrays
    tag_t            tag_mem  [2][SETS];
    line_t           data_mem [2][SETS];
    logic [SETS-1:0] valid    [2];

    // registered read ports
    tag_t       tag_q  [2];
    line_t      data_q [2];
    logic [1:0] valid_q;

    // lru bit holds the most recently used way
    logic [SETS-1:0] lru;
    logic [1:0]      hit_vec;
    way_t            victim;
    way_t            touch_way;

    assign rd_index = i_fetch_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_index = i_req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign req_tag  = i_req_addr[31 -: `ICACHE_TAG_W];

    always_ff @(posedge clk) begin
        if (i_line_we) begin
            tag_mem[victim][wr_index]  <= req_tag;
            data_mem[victim][wr_index] <= i_ret_line;
        end
        if (i_accept) begin
            for (int w = 0; w < 2; w++) begin
                tag_q[w]  <= tag_mem[w][rd_index];
                data_q[w] <= data_mem[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid[0] <= '0;
            valid[1] <= '0;
            valid_q  <= '0;
            lru      <= '0;
        end else begin
            if (i_line_we) begin
                valid[victim][wr_index] <= 1'b1;
            end
            if (i_accept) begin
                valid_q <= {valid[1][rd_index], valid[0][rd_index]};
            end
            if (i_lru_touch) begin
                lru[wr_index] <= touch_way;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = valid_q[w] && (tag_q[w] == req_tag);
        end
    end

    assign o_hit      = |hit_vec;
    assign o_hit_way  = hit_vec[1];
    assign o_hit_line = data_q[o_hit_way];

    // fill an empty way first, else evict the older one
    always_comb begin
        if (!valid_q[0]) begin
            victim = 1'b0;
        end else if (!valid_q[1]) begin
            victim = 1'b1;
        end else begin
            victim = ~lru[wr_index];
        end
    end

    assign touch_way = i_line_we ? victim : o_hit_way;

    // refill only follows a miss, so a tag lives in one way at most
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        !(hit_vec[0] && hit_vec[1])
    ) else $error("both ways hit the same address");

endmodule

//--- icache/icache_req_buf.sv
`include "icache_macros.svh"

module icache_req_buf (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_accept,
    input  icache_pkg::addr_t  i_fetch_addr,
    input  logic               i_fetch_uncached,
    input  logic               i_mem_ready,
    input  icache_pkg::line_t  i_mem_data,
    output icache_pkg::addr_t  o_req_addr,
    output logic               o_uncached,
    output logic               o_misaligned,
    output icache_pkg::addr_t  o_mem_addr,
    output logic [7:0]         o_mem_len,
    output icache_pkg::line_t  o_ret_line
);
    import icache_pkg::*;

    addr_t req_addr;
    logic  uncached;
    line_t ret_line;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_addr <= '0;
            uncached <= 1'b0;
        end else if (i_accept) begin
            req_addr <= i_fetch_addr;
            uncached <= i_fetch_uncached;
        end
    end

    // whole line or doubleword from memory
    always_ff @(posedge clk) begin
        if (i_mem_ready) begin
            ret_line <= i_mem_data;
        end
    end

    assign o_req_addr   = req_addr;
    assign o_uncached   = uncached;
    assign o_misaligned = |req_addr[1:0];
    assign o_ret_line   = ret_line;

    // doubleword aligned for uncached, else line aligned
    assign o_mem_addr = uncached ? {req_addr[31:3], 3'b000}
                                 : {req_addr[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    assign o_mem_len  = uncached ? 8'(`ICACHE_UNC_BEATS) : 8'(`ICACHE_LINE_BEATS);

endmodule

//--- icache/icache_ctrl.sv
module icache_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic i_fetch_valid,
    input  logic i_hit,
    input  logic i_misaligned,
    input  logic i_uncached,
    input  logic i_mem_ready,
    output logic o_fetch_ready,
    output logic o_accept,
    output logic o_line_we,
    output logic o_lru_touch,
    output logic o_from_mem,
    output logic o_mem_req,
    output logic o_resp_valid
);
    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // lookup outcome for the held request
    logic lookup_done;
    logic lookup_hit;

    // misaligned answers at once without a memory access
    assign lookup_hit  = i_hit && !i_uncached && !i_misaligned;
    assign lookup_done = i_misaligned || lookup_hit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (o_accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!lookup_done) begin
                    next_state = MISS;
                end else if (o_accept) begin
                    next_state = LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                if (i_mem_ready) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // back-to-back accept only after a lookup that answers
    assign o_fetch_ready = (state == IDLE) || ((state == LOOKUP) && lookup_done);
    assign o_accept      = i_fetch_valid && o_fetch_ready;

    assign o_resp_valid = ((state == LOOKUP) && lookup_done) || (state == REFILL);
    assign o_mem_req    = (state == MISS);
    assign o_from_mem   = (state == REFILL);

    // uncached data never lands in the arrays
    assign o_line_we   = (state == REFILL) && !i_uncached;
    assign o_lru_touch = ((state == LOOKUP) && lookup_hit) || o_line_we;

    // memory request stays up until the memory takes it
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (o_mem_req && !i_mem_ready) |=> o_mem_req
    ) else $error("memory request dropped before i_mem_ready");

    // memory answers only an outstanding request
    a_ready_with_req: assert property (
        @(posedge clk) disable iff (!rstn)
        i_mem_ready |-> o_mem_req
    ) else $error("i_mem_ready raised with no memory request pending");

endmodule

//--- common/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // fetch and memory addresses
    typedef logic [31:0] addr_t;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    // one full cache line
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // dual-issue instruction pair
    typedef logic [`ICACHE_FETCH_W-1:0] fetch_t;

    // way number, two ways
    typedef logic way_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } ctrl_state_t;

endpackage

//--- common/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_INDEX_W      6
`define ICACHE_OFFSET_W     6
`define ICACHE_TAG_W        (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// data widths
`define ICACHE_LINE_W       512
`define ICACHE_FETCH_W      64

// burst length codes, n means n+1 beats
`define ICACHE_LINE_BEATS   15
`define ICACHE_UNC_BEATS    1

// andi r0, r0, 0
`define ICACHE_INST_NOP     32'h0340_0000

`endif
